/* data_cache.f */
+incdir+src
src/cache_pkg.sv
src/line_store.sv
src/line_arbiter.sv
src/host_port.sv
src/ddr_engine.sv
src/cache_ctrl.sv
src/data_cache.sv
sim/data_cache_checker.sv
sim/data_cache_tb.sv

/* sim/data_cache_tb.sv */
`default_nettype none

`include "cache_settings.svh"

module data_cache_tb
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        cache_cmd_e cmd;
        word_t      row;
        column_t    col;
        logic       fill;
        logic       wb;
        mem_addr_t  tag;
    } expect_t;

    localparam int directed_ops = 10;
    localparam int random_ops = 200;
    localparam int timeout_cycles = 400 * (directed_ops + random_ops) + 16;

    logic      clk = 1'b0;
    logic      rst = 1'b0;
    host_req_t host_req = '0;
    logic      store_ddr_en = 1'b0;
    logic      ready;
    word_t     row_out;
    column_t   col_out;
    ddr_cmd_t  ddr_rd;
    logic      rd_valid = 1'b0;
    word_t     rd_data = '0;
    ddr_cmd_t  ddr_wr;
    logic      wr_req = 1'b0;
    word_t     wr_data;
    logic      wr_valid;

    mem_addr_t model_tag = '0;
    logic      model_valid = 1'b0;
    word_t     model_line [`LINE_WORDS];
    expect_t   expected_q [$];
    expect_t   cur;

    int          issued = 0;
    int          completed = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          err_mark;

    int        rd_count = 0;  // strobes given for the open fill
    int        fill_reqs = 0;
    int        wb_reqs = 0;
    int        wr_total = 0;
    logic      rd_req_prev = 1'b0;
    logic      wr_req_prev = 1'b0;
    ddr_addr_t rd_addr_seen = '0;
    ddr_addr_t wr_addr_seen = '0;
    word_t     wb_buf [`LINE_WORDS];
    int        fill_mark = 0;
    int        wb_mark = 0;
    int        wr_mark = 0;

    data_cache data_cache_inst (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .store_ddr_en (store_ddr_en),
        .ready        (ready),
        .row_out      (row_out),
        .col_out      (col_out),
        .ddr_rd       (ddr_rd),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .ddr_wr       (ddr_wr),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .wr_valid     (wr_valid)
    );

    always #20 clk = ~clk;

    function automatic word_t ddr_word(input ddr_addr_t a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    // updates the model line and returns what the DUT should answer
    function automatic expect_t predict(input host_req_t req, input logic ddr_en);
        expect_t   res;
        mem_addr_t offset;
        logic      hit;
        int        idx;
        res = '0;
        res.cmd = req.cmd;
        offset = req.addr - model_tag;
        hit = model_valid && (offset < `LINE_WORDS);
        idx = hit ? int'(offset) : 0;
        case (req.cmd)
            cmd_row_load, cmd_col_load:
            begin
                if (!hit)
                begin
                    model_tag = req.addr;
                    model_valid = 1'b1;
                    res.fill = 1'b1;
                    for (int i = 0; i < `LINE_WORDS; i++)
                    begin
                        model_line[i] = ddr_word(ddr_addr_t'((int'(req.addr) + i) * `DDR_ADDR_SCALE));
                    end
                end
            end
            cmd_row_store:
            begin
                if (!hit)
                begin
                    model_tag = req.addr;  // retag only and keep the old words
                    model_valid = 1'b1;
                end
                model_line[idx] = req.row_data;
                res.wb = ddr_en;
            end
            cmd_col_store:
            begin
                model_tag = req.addr;
                model_valid = 1'b1;
                for (int i = 0; i < `LINE_WORDS; i++)
                begin
                    model_line[i][req.col] = req.col_data[i];
                end
                res.wb = ddr_en;
            end
            default:
            begin
            end
        endcase
        res.row = model_line[idx];
        for (int i = 0; i < `LINE_WORDS; i++)
        begin
            res.col[i] = model_line[i][req.col];
        end
        res.tag = model_tag;
        return res;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("FAIL t=%0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic run_op(input cache_cmd_e cmd, input mem_addr_t addr, input bit_sel_t col,
                          input word_t row_data, input column_t col_data, input logic ddr_en);
        host_req_t req;
        req.cmd = cmd;
        req.addr = addr;
        req.col = col;
        req.row_data = row_data;
        req.col_data = col_data;
        @(negedge clk);
        expected_q.push_back(predict(req, ddr_en));
        host_req = req;
        store_ddr_en = ddr_en;
        issued++;
        wait (completed == issued);
    endtask

    task automatic run_random_ops(input int count);
        cache_cmd_e cmd;
        mem_addr_t  addr;
        for (int n = 0; n < count; n++)
        begin
            cmd = cache_cmd_e'(3'($urandom_range(4, 1)));
            addr = mem_addr_t'(16'h0200 + $urandom_range(39, 0));  // mix of hits and misses
            run_op(cmd, addr, bit_sel_t'($urandom), word_t'($urandom), column_t'($urandom),
                   ($urandom_range(3, 0) == 0));
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // DDR model returning words in line order at eight address steps per word
    always @(negedge clk)
    begin
        rd_valid = 1'b0;
        wr_req = 1'b0;
        if (ddr_rd.req && !rd_req_prev)
        begin
            fill_reqs++;
        end
        if (ddr_wr.req && !wr_req_prev)
        begin
            wb_reqs++;
        end
        rd_req_prev = ddr_rd.req;
        wr_req_prev = ddr_wr.req;
        if (!ddr_rd.req)
        begin
            rd_count = 0;
        end
        else if ((rd_count < `LINE_WORDS) && ($urandom_range(2, 0) != 0))
        begin
            rd_addr_seen = ddr_rd.addr;
            rd_data = ddr_word(ddr_rd.addr + ddr_addr_t'(rd_count * `DDR_ADDR_SCALE));
            rd_valid = 1'b1;
            rd_count++;
        end
        if (ddr_wr.req && ($urandom_range(2, 0) != 0))
        begin
            wr_req = 1'b1;
        end
        if (wr_valid)
        begin
            wb_buf[wr_total % `LINE_WORDS] = wr_data;
            wr_addr_seen = ddr_wr.addr;
            wr_total++;
        end
    end

    always @(negedge clk)
    begin
        if (rst && ready)
        begin
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("ready pulsed at %0t with no command outstanding", $time);
            end
            else
            begin
                cur = expected_q.pop_front();
                if (cur.cmd == cmd_row_load)
                begin
                    check("row_out", row_out, cur.row);
                end
                if (cur.cmd == cmd_col_load)
                begin
                    check("col_out", col_out, cur.col);
                end
                check("fill requests", fill_reqs - fill_mark, cur.fill);
                check("write-back requests", wb_reqs - wb_mark, cur.wb);
                if (cur.fill)
                begin
                    check("fill address", rd_addr_seen, 32'(cur.tag) * `DDR_ADDR_SCALE);
                end
                check("write-back words", wr_total - wr_mark, cur.wb ? `LINE_WORDS : 0);
                if (cur.wb && (wr_total - wr_mark == `LINE_WORDS))
                begin
                    check("write-back address", wr_addr_seen, 32'(cur.tag) * `DDR_ADDR_SCALE);
                    for (int i = 0; i < `LINE_WORDS; i++)
                    begin
                        check($sformatf("write-back word %0d", i),
                              wb_buf[(wr_mark + i) % `LINE_WORDS], model_line[i]);
                    end
                end
            end
            fill_mark = fill_reqs;
            wb_mark = wb_reqs;
            wr_mark = wr_total;
            completed++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout, the run was stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'hf233_237b));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        err_mark = errors;
        run_op(cmd_row_load, 16'h0040, 4'd0, '0, '0, 1'b0);
        report_test(1, "row load miss", err_mark);

        err_mark = errors;
        run_op(cmd_row_store, 16'h0043, 4'd0, 16'hbeef, '0, 1'b0);
        run_op(cmd_row_load, 16'h0043, 4'd0, '0, '0, 1'b0);
        run_op(cmd_row_load, 16'h0040, 4'd0, '0, '0, 1'b0);
        run_op(cmd_row_load, 16'h004f, 4'd0, '0, '0, 1'b0);
        report_test(2, "row store and hits", err_mark);

        err_mark = errors;
        run_op(cmd_col_store, 16'h0040, 4'd5, '0, 16'ha5c3, 1'b0);
        run_op(cmd_col_load, 16'h0040, 4'd5, '0, '0, 1'b0);
        run_op(cmd_row_load, 16'h0041, 4'd0, '0, '0, 1'b0);
        run_op(cmd_row_load, 16'h004e, 4'd0, '0, '0, 1'b0);
        report_test(3, "column store and load", err_mark);

        err_mark = errors;
        run_op(cmd_row_store, 16'h0047, 4'd0, 16'h1234, '0, 1'b1);
        report_test(4, "store with write-back", err_mark);

        err_mark = errors;
        run_random_ops(random_ops);
        report_test(5, "random operations", err_mark);

        @(negedge clk);
        host_req = '0;
        store_ddr_en = 1'b0;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/data_cache_checker.sv */
`default_nettype none

`include "cache_settings.svh"

module data_cache_checker
    import cache_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire           ready,
    input wire ddr_cmd_t ddr_rd,
    input wire           rd_valid,
    input wire ddr_cmd_t ddr_wr,
    input wire           wr_req,
    input wire           wr_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [4:0] rd_seen;  // fill strobes since the read request rose

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_seen <= '0;
        end
        else if (!ddr_rd.req)
        begin
            rd_seen <= '0;
        end
        else if (rd_valid)
        begin
            rd_seen <= rd_seen + 1'b1;
        end
    end

    ready_one_cycle: assert property (@(posedge clk) disable iff (!rst) ready |=> !ready)
        else $error("ready stayed high for two cycles");

    fill_complete: assert property (@(posedge clk) disable iff (!rst)
        $fell(ddr_rd.req) |-> (rd_seen == `LINE_WORDS))
        else $error("read request dropped before sixteen words arrived");

    ready_after_ddr: assert property (@(posedge clk) disable iff (!rst)
        (ddr_rd.req || ddr_wr.req) |-> !ready)
        else $error("ready raised while a DDR request is open");

    wr_valid_follows_req: assert property (@(posedge clk) disable iff (!rst)
        wr_valid |-> $past(wr_req))
        else $error("write data strobe without a preceding wr_req");

endmodule

bind data_cache data_cache_checker data_cache_checker_inst (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .ddr_rd   (ddr_rd),
    .rd_valid (rd_valid),
    .ddr_wr   (ddr_wr),
    .wr_req   (wr_req),
    .wr_valid (wr_valid)
);

`default_nettype wire

/* src/data_cache.sv */
`default_nettype none

module data_cache
    import cache_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire host_req_t host_req,
    input  wire            store_ddr_en,
    output logic           ready,
    output word_t          row_out,
    output column_t        col_out,
    output ddr_cmd_t       ddr_rd,
    input  wire            rd_valid,
    input  wire word_t     rd_data,
    output ddr_cmd_t       ddr_wr,
    input  wire            wr_req,
    output word_t          wr_data,
    output logic           wr_valid
);

    engine_op_t engine_op;
    logic       engine_done;
    mem_addr_t  line_tag;
    logic       serve;
    logic       served;
    index_t     index;
    logic       host_want;
    logic       engine_want;
    logic       host_grant;
    logic       engine_grant;
    mem_req_t   host_mem_req;
    mem_req_t   engine_mem_req;
    mem_req_t   mem_req;
    word_t      row_rd;
    column_t    col_rd;

    cache_ctrl cache_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .store_ddr_en (store_ddr_en),
        .engine_done  (engine_done),
        .served       (served),
        .engine_op    (engine_op),
        .line_tag     (line_tag),
        .serve        (serve),
        .index        (index),
        .ready        (ready)
    );

    host_port host_port_inst (
        .clk      (clk),
        .rst      (rst),
        .serve    (serve),
        .index    (index),
        .host_req (host_req),
        .grant    (host_grant),
        .row_rd   (row_rd),
        .col_rd   (col_rd),
        .want     (host_want),
        .mem_req  (host_mem_req),
        .served   (served),
        .row_out  (row_out),
        .col_out  (col_out)
    );

    ddr_engine ddr_engine_inst (
        .clk         (clk),
        .rst         (rst),
        .engine_op   (engine_op),
        .line_tag    (line_tag),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .wr_req      (wr_req),
        .grant       (engine_grant),
        .row_rd      (row_rd),
        .want        (engine_want),
        .mem_req     (engine_mem_req),
        .ddr_rd      (ddr_rd),
        .ddr_wr      (ddr_wr),
        .wr_data     (wr_data),
        .wr_valid    (wr_valid),
        .engine_done (engine_done)
    );

    line_arbiter line_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .host_want    (host_want),
        .host_req     (host_mem_req),
        .engine_want  (engine_want),
        .engine_req   (engine_mem_req),
        .mem_req      (mem_req),
        .host_grant   (host_grant),
        .engine_grant (engine_grant)
    );

    line_store line_store_inst (
        .clk    (clk),
        .rst    (rst),
        .req    (mem_req),
        .row_rd (row_rd),
        .col_rd (col_rd)
    );

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire host_req_t host_req,
    input  wire            store_ddr_en,
    input  wire            engine_done,
    input  wire            served,
    output engine_op_t     engine_op,
    output mem_addr_t      line_tag,
    output logic           serve,
    output index_t         index,
    output logic           ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_fill,
        st_access,
        st_writeback
    } ctrl_state_e;

    ctrl_state_e state;
    logic        tag_valid;
    logic        wb_pending;  // current store ends with a write-back
    mem_addr_t   offset;
    logic        hit;
    logic        is_load;
    logic        is_store;

    assign offset = host_req.addr - line_tag;
    assign hit = tag_valid && (offset < `LINE_WORDS);
    assign is_load = (host_req.cmd == cmd_row_load) || (host_req.cmd == cmd_col_load);
    assign is_store = (host_req.cmd == cmd_row_store) || (host_req.cmd == cmd_col_store);

    assign ready = ((state == st_access) && served && !wb_pending) ||
                   ((state == st_writeback) && engine_done);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= st_idle;
            line_tag <= '0;
            tag_valid <= 1'b0;
            wb_pending <= 1'b0;
            serve <= 1'b0;
            engine_op <= op_idle;
            index <= '0;
        end
        else
        begin
            serve <= 1'b0;
            engine_op <= op_idle;
            case (state)
                st_idle:
                begin
                    if (is_load || is_store)
                    begin
                        wb_pending <= is_store && store_ddr_en;
                        if (is_load && !hit)
                        begin
                            line_tag <= host_req.addr;
                            tag_valid <= 1'b1;
                            index <= '0;
                            engine_op <= op_fill;
                            state <= st_fill;
                        end
                        else if (is_load || ((host_req.cmd == cmd_row_store) && hit))
                        begin
                            index <= index_t'(offset);
                            serve <= 1'b1;
                            state <= st_access;
                        end
                        else
                        begin
                            // store miss or column store retags the line, no fill
                            line_tag <= host_req.addr;
                            tag_valid <= 1'b1;
                            index <= '0;
                            serve <= 1'b1;
                            state <= st_access;
                        end
                    end
                end
                st_fill:
                begin
                    if (engine_done)
                    begin
                        serve <= 1'b1;
                        state <= st_access;
                    end
                end
                st_access:
                begin
                    if (served)
                    begin
                        if (wb_pending)
                        begin
                            engine_op <= op_writeback;
                            state <= st_writeback;
                        end
                        else
                        begin
                            state <= st_idle;
                        end
                    end
                end
                default:
                begin
                    if (engine_done)
                    begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ddr_engine.sv */
`default_nettype none

`include "cache_settings.svh"

module ddr_engine
    import cache_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire engine_op_t engine_op,
    input  wire mem_addr_t  line_tag,
    input  wire             rd_valid,
    input  wire word_t      rd_data,
    input  wire             wr_req,
    input  wire             grant,
    input  wire word_t      row_rd,
    output logic            want,
    output mem_req_t        mem_req,
    output ddr_cmd_t        ddr_rd,
    output ddr_cmd_t        ddr_wr,
    output word_t           wr_data,
    output logic            wr_valid,
    output logic            engine_done
);

    localparam index_t last_index = index_t'(`LINE_WORDS - 1);

    engine_op_t state;
    index_t     count;
    logic       wb_last;  // sixteenth word is on its way out
    ddr_addr_t  line_addr;

    assign line_addr = ddr_addr_t'(line_tag) * ddr_addr_t'(`DDR_ADDR_SCALE);

    assign ddr_rd.req = (state == op_fill);
    assign ddr_rd.addr = line_addr;
    assign ddr_wr.req = (state == op_writeback);
    assign ddr_wr.addr = line_addr;

    assign want = ((state == op_fill) && rd_valid) ||
                  ((state == op_writeback) && wr_req && !wb_last);

    always_comb
    begin
        mem_req = '0;
        mem_req.index = count;
        mem_req.row_data = rd_data;
        mem_req.row_we = (state == op_fill);  // write-back only reads
    end

    // word read on the wr_req cycle comes back with wr_valid
    assign wr_data = row_rd;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= op_idle;
            count <= '0;
            wb_last <= 1'b0;
            wr_valid <= 1'b0;
            engine_done <= 1'b0;
        end
        else
        begin
            wr_valid <= (state == op_writeback) && want && grant;
            engine_done <= 1'b0;
            case (state)
                op_idle:
                begin
                    if (engine_op != op_idle)
                    begin
                        state <= engine_op;
                        count <= '0;
                    end
                end
                op_fill:
                begin
                    if (want && grant)
                    begin
                        count <= count + 1'b1;
                        if (count == last_index)
                        begin
                            state <= op_idle;
                            engine_done <= 1'b1;
                        end
                    end
                end
                op_writeback:
                begin
                    if (wb_last)
                    begin
                        state <= op_idle;
                        wb_last <= 1'b0;
                        engine_done <= 1'b1;
                    end
                    else if (want && grant)
                    begin
                        count <= count + 1'b1;
                        wb_last <= (count == last_index);
                    end
                end
                default:
                begin
                    state <= op_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/host_port.sv */
`default_nettype none

`include "cache_settings.svh"

module host_port
    import cache_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            serve,
    input  wire index_t    index,
    input  wire host_req_t host_req,
    input  wire            grant,
    input  wire word_t     row_rd,
    input  wire column_t   col_rd,
    output logic           want,
    output mem_req_t       mem_req,
    output logic           served,
    output word_t          row_out,
    output column_t        col_out
);

    mem_req_t built;
    logic     pending;
    word_t    row_hold;
    column_t  col_hold;

    always_comb
    begin
        built = '0;
        built.index = index;
        built.col = host_req.col;
        built.row_data = host_req.row_data;
        built.col_data = host_req.col_data;
        built.row_we = (host_req.cmd == cmd_row_store);
        built.col_we = (host_req.cmd == cmd_col_store);  // loads go out as plain reads
    end

    assign want = serve || pending;
    assign mem_req = built;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pending <= 1'b0;
            served <= 1'b0;
        end
        else
        begin
            pending <= want && !grant;  // retry after losing to the engine
            served <= want && grant;
        end
    end

    always_ff @(posedge clk)
    begin
        if (served)
        begin
            row_hold <= row_rd;
            col_hold <= col_rd;
        end
    end

    // the line answers one cycle after the grant
    assign row_out = served ? row_rd : row_hold;
    assign col_out = served ? col_rd : col_hold;

endmodule

`default_nettype wire

/* src/line_arbiter.sv */
`default_nettype none

`include "cache_settings.svh"

module line_arbiter
    import cache_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           host_want,
    input  wire mem_req_t host_req,
    input  wire           engine_want,
    input  wire mem_req_t engine_req,
    output mem_req_t      mem_req,
    output logic          host_grant,
    output logic          engine_grant
);

    mem_req_t held;  // last granted access, writes stripped

    always_comb
    begin
        engine_grant = engine_want;
        host_grant = host_want && !engine_want;  // DDR strobes cannot wait
        if (engine_grant)
        begin
            mem_req = engine_req;
        end
        else if (host_grant)
        begin
            mem_req = host_req;
        end
        else
        begin
            mem_req = held;  // keeps the read data of the last owner on the bus
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            held <= '0;
        end
        else if (engine_want || host_want)
        begin
            held <= mem_req;
            held.row_we <= 1'b0;
            held.col_we <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/line_store.sv */
`default_nettype none

`include "cache_settings.svh"

module line_store
    import cache_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire mem_req_t req,
    output word_t         row_rd,
    output column_t       col_rd
);

    word_t mem [`LINE_WORDS];

    always_ff @(posedge clk)
    begin
        if (req.row_we)
        begin
            mem[req.index] <= req.row_data;
        end
        else if (req.col_we)
        begin
            for (int i = 0; i < `LINE_WORDS; i++)
            begin
                mem[i][req.col] <= req.col_data[i];  // one bit lands in every word
            end
        end
    end

    // reads see the line as it was before a write in the same cycle
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            row_rd <= '0;
            col_rd <= '0;
        end
        else
        begin
            row_rd <= mem[req.index];
            for (int i = 0; i < `LINE_WORDS; i++)
            begin
                col_rd[i] <= mem[i][req.col];
            end
        end
    end

endmodule

`default_nettype wire

/* src/cache_pkg.sv */
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        cmd_none      = 3'd0,
        cmd_row_load  = 3'd1,
        cmd_row_store = 3'd2,
        cmd_col_load  = 3'd3,
        cmd_col_store = 3'd4
    } cache_cmd_e;

    typedef enum logic [1:0] {
        op_idle      = 2'd0,
        op_fill      = 2'd1,
        op_writeback = 2'd2
    } engine_op_t;

    typedef logic [`WORD_BITS-1:0]             word_t;
    typedef logic [`LINE_WORDS-1:0]            column_t;  // one bit from each word of the line
    typedef logic [$clog2(`LINE_WORDS)-1:0]    index_t;
    typedef logic [$clog2(`WORD_BITS)-1:0]     bit_sel_t;
    typedef logic [`MEM_ADDR_BITS-1:0]         mem_addr_t;
    typedef logic [`DDR_ADDR_BITS-1:0]         ddr_addr_t;

    typedef struct packed {
        cache_cmd_e cmd;
        mem_addr_t  addr;
        bit_sel_t   col;
        word_t      row_data;
        column_t    col_data;
    } host_req_t;

    typedef struct packed {
        logic     row_we;
        logic     col_we;
        index_t   index;
        bit_sel_t col;
        word_t    row_data;
        column_t  col_data;
    } mem_req_t;

    typedef struct packed {
        logic      req;
        ddr_addr_t addr;
    } ddr_cmd_t;

endpackage

`default_nettype wire

/* src/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// words held by the line, also the width of a column value
`define LINE_WORDS 16

// width of one data word
`define WORD_BITS 16

// host word address width
`define MEM_ADDR_BITS 16

// DDR byte-lane address width
`define DDR_ADDR_BITS 28

// one host word spans eight DDR address steps
`define DDR_ADDR_SCALE 8

`endif
